// File: src/sdmacPkg.sv
`default_nettype none

package sdmacPkg;

  localparam int WORD_W    = 32;
  localparam int ADDR_W    = 24;
  localparam int CNT_W     = 8;
  localparam int NUM_TERMS = 22;

  typedef enum logic [4:0] {
    S_IDLE    = 5'd0,
    S_NEXT    = 5'd1,   // choose next word or stall
    S_REQ     = 5'd2,   // busReq up, wait for grant
    S_DONE    = 5'd3,
    S_ADDR    = 5'd8,   // strobes driven
    S_FLUSH   = 5'd11,  // read side, fifo full
    S_ACK16   = 5'd14,  // lower half done on 16 bit port
    S_WAITACK = 5'd28
  } smState_t;

  // exit terms first, output terms from T_BUSREQ up
  typedef enum int {
    T_IDLE_START   = 0,
    T_NEXT_WR      = 1,
    T_NEXT_FLUSH   = 2,
    T_NEXT_RD      = 3,
    T_NEXT_FULL    = 4,
    T_NEXT_ABORT   = 5,
    T_FLUSH_FREE   = 6,
    T_REQ_GRANT    = 7,
    T_ADDR_WAIT    = 8,
    T_ACK32_MORE   = 9,
    T_ACK32_LAST   = 10,
    T_ACK16_LO     = 11,
    T_ACK16_MORE   = 12,
    T_ACK16_LAST   = 13,
    T_HALF_GRANT   = 14,
    T_HALF_REGRANT = 15,
    T_DONE_EXIT    = 16,
    T_BUSREQ       = 17,
    T_STROBE       = 18,
    T_HALF_DONE    = 19,
    T_BUS_POP      = 20,
    T_BUS_PUSH     = 21
  } termIdx_t;

  typedef struct packed {
    logic       enable;
    logic       toMemory;
    logic       flush;
    logic       fifoEmpty;
    logic       fifoFull;
    logic       lastWord;
    logic       a1;
    logic       grantN;
    logic       cycleDone;
    logic [1:0] dsackN;     // {dsack1N, dsack0N}
  } smFlags_t;

  typedef struct packed {
    logic enable;
    logic toMemory;
    logic flush;
  } dmaCtrl_t;

  typedef struct packed {
    logic              busReq;
    logic              addrStrobe;
    logic              dataStrobe;
    logic              readWrite;  // 1 = read from memory
    logic [ADDR_W-1:0] addr;
    logic [WORD_W-1:0] dataOut;
  } cpuBusOut_t;

endpackage

`default_nettype wire

// File: src/dmaFifo.sv
`timescale 1ns/100ps
`default_nettype none

module dmaFifo #(
  parameter int DEPTH = 8
) (
  input  logic                        CLK,
  input  logic                        rstN,
  input  logic                        clear,
  input  logic                        push,
  input  logic [sdmacPkg::WORD_W-1:0] pushData,
  input  logic                        pop,
  output logic [sdmacPkg::WORD_W-1:0] popData,
  output logic                        empty,
  output logic                        full
);

  import sdmacPkg::*;

  localparam int PTR_W = $clog2(DEPTH);

  logic [WORD_W-1:0] mem [DEPTH];
  logic [PTR_W:0]    wrPtr;  // extra msb tells full from empty
  logic [PTR_W:0]    rdPtr;
  logic              doPush;
  logic              doPop;

  assign doPush  = push & ~full;   // overflow dropped
  assign doPop   = pop & ~empty;
  assign empty   = (wrPtr == rdPtr);
  assign full    = (wrPtr[PTR_W] != rdPtr[PTR_W]) &
                   (wrPtr[PTR_W-1:0] == rdPtr[PTR_W-1:0]);
  assign popData = mem[rdPtr[PTR_W-1:0]];  // fall-through head word

  always_ff @(posedge CLK) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
    end else if (clear) begin
      wrPtr <= '0;
      rdPtr <= '0;
    end else begin
      if (doPush)
        wrPtr <= wrPtr + 1'b1;
      if (doPop)
        rdPtr <= rdPtr + 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (doPush)
      mem[wrPtr[PTR_W-1:0]] <= pushData;
  end

  noOverflow: assert property (@(posedge CLK) disable iff (!rstN)
    push && !clear |-> !full)
    else $error("dmaFifo: push while full, word dropped");

  noUnderflow: assert property (@(posedge CLK) disable iff (!rstN)
    pop && !clear |-> !empty)
    else $error("dmaFifo: pop while empty");

endmodule

`default_nettype wire

// File: src/dmaAddrCounter.sv
`timescale 1ns/100ps
`default_nettype none

module dmaAddrCounter (
  input  logic                        CLK,
  input  logic                        rstN,
  input  logic                        load,
  input  logic [sdmacPkg::ADDR_W-1:0] startAddr,
  input  logic [sdmacPkg::CNT_W-1:0]  wordCount,
  input  logic                        advance,
  input  logic                        halfStep,
  output logic [sdmacPkg::ADDR_W-1:0] addr,
  output logic                        a1,
  output logic                        lastWord
);

  import sdmacPkg::*;

  logic [CNT_W-1:0]  remaining;
  logic [ADDR_W-1:0] step;
  logic              wordEnd;

  assign step    = halfStep ? ADDR_W'(2) : ADDR_W'(4);
  assign wordEnd = ~halfStep | addr[1];  // upper half closes the word

  always_ff @(posedge CLK) begin
    if (!rstN) begin
      addr      <= '0;
      remaining <= '0;
    end else if (load) begin
      addr      <= startAddr;
      remaining <= wordCount;
    end else if (advance) begin
      addr <= addr + step;
      if (wordEnd)
        remaining <= remaining - 1'b1;
    end
  end

  assign a1       = addr[1];
  assign lastWord = (remaining == CNT_W'(1));

endmodule

`default_nettype wire

// File: src/cpuSmInputs.sv
`timescale 1ns/100ps
`default_nettype none

module cpuSmInputs (
  input  sdmacPkg::smState_t             state,
  input  sdmacPkg::smFlags_t             flags,
  output logic [sdmacPkg::NUM_TERMS-1:0] terms
);

  import sdmacPkg::*;

  localparam int NUM_EXIT = T_BUSREQ;  // terms below this pick a new state

  logic en;
  logic toMem;
  logic flushReq;
  logic empty;
  logic full;
  logic last;
  logic a1;
  logic gntN;
  logic cycDone;
  logic ack32;
  logic ack16;
  logic wordAck;

  assign en       = flags.enable;
  assign toMem    = flags.toMemory;
  assign flushReq = flags.flush;
  assign empty    = flags.fifoEmpty;
  assign full     = flags.fifoFull;
  assign last     = flags.lastWord;
  assign a1       = flags.a1;
  assign gntN     = flags.grantN;
  assign cycDone  = flags.cycleDone;

  assign ack32   = (flags.dsackN == 2'b00);
  assign ack16   = (flags.dsackN == 2'b01);
  assign wordAck = ack32 | (ack16 & a1);  // upper half also ends the word

  assign terms[T_IDLE_START]   = (state == S_IDLE) & en;                              // s0
  assign terms[T_NEXT_WR]      = (state == S_NEXT) & en & toMem & ~empty;             // s1
  assign terms[T_NEXT_FLUSH]   = (state == S_NEXT) & en & toMem & empty & flushReq;   // s1
  assign terms[T_NEXT_RD]      = (state == S_NEXT) & en & ~toMem & ~full;             // s1
  assign terms[T_NEXT_FULL]    = (state == S_NEXT) & en & ~toMem & full;              // s1
  assign terms[T_NEXT_ABORT]   = (state == S_NEXT) & ~en;                             // s1
  assign terms[T_FLUSH_FREE]   = (state == S_FLUSH) & ~full;                          // s11
  assign terms[T_REQ_GRANT]    = (state == S_REQ) & ~gntN & cycDone;                  // s2
  assign terms[T_ADDR_WAIT]    = (state == S_ADDR);                                   // s8
  assign terms[T_ACK32_MORE]   = (state == S_WAITACK) & ack32 & ~last;                // s28
  assign terms[T_ACK32_LAST]   = (state == S_WAITACK) & ack32 & last;                 // s28
  assign terms[T_ACK16_LO]     = (state == S_WAITACK) & ack16 & ~a1;                  // s28
  assign terms[T_ACK16_MORE]   = (state == S_WAITACK) & ack16 & a1 & ~last;           // s28
  assign terms[T_ACK16_LAST]   = (state == S_WAITACK) & ack16 & a1 & last;            // s28
  assign terms[T_HALF_GRANT]   = (state == S_ACK16) & ~gntN & cycDone;                // s14
  assign terms[T_HALF_REGRANT] = (state == S_ACK16) & gntN;                           // s14
  assign terms[T_DONE_EXIT]    = (state == S_DONE) & ~en;                             // s3

  // output terms, not state exits
  assign terms[T_BUSREQ]   = (state == S_REQ) | (state == S_ADDR) |
                             (state == S_WAITACK) | (state == S_ACK16);   // s2, s8, s28, s14
  assign terms[T_STROBE]   = (state == S_ADDR) |
                             ((state == S_WAITACK) & flags.dsackN[1]);    // s8 or s28
  assign terms[T_HALF_DONE] = (state == S_WAITACK) & ack16;               // s28
  assign terms[T_BUS_POP]   = (state == S_WAITACK) & toMem & wordAck;     // s28
  assign terms[T_BUS_PUSH]  = (state == S_WAITACK) & ~toMem & wordAck;    // s28

  // the OR-plane relies on one exit per state
  always_comb begin
    assert ($onehot0(terms[NUM_EXIT-1:0]))
      else $error("cpuSmInputs: several exit terms active in state %0d", state);
  end

endmodule

`default_nettype wire

// File: src/cpuSmCore.sv
`timescale 1ns/100ps
`default_nettype none

module cpuSmCore (
  input  logic                           CLK,
  input  logic                           rstN,
  input  logic [sdmacPkg::NUM_TERMS-1:0] terms,
  input  sdmacPkg::smFlags_t             flags,
  input  logic [sdmacPkg::WORD_W-1:0]    fifoData,
  input  logic [sdmacPkg::WORD_W-1:0]    busDataIn,
  input  logic [sdmacPkg::ADDR_W-1:0]    addr,
  output sdmacPkg::smState_t             state,
  output sdmacPkg::cpuBusOut_t           busOut,
  output logic                           fifoPushBus,
  output logic [sdmacPkg::WORD_W-1:0]    fifoPushData,
  output logic                           fifoPopBus,
  output logic                           addrAdvance,
  output logic                           halfStep,
  output logic                           cycleDone,
  output logic                           done
);

  import sdmacPkg::*;

  localparam int HALF_W = WORD_W / 2;

  smState_t          nextState;
  logic              toIdle;
  logic              toNext;
  logic              toReq;
  logic              toAddr;
  logic              toWait;
  logic              toAck16;
  logic              toDone;
  logic              toFlush;
  logic              wordDone;
  logic [HALF_W-1:0] lowHalf;  // first half of a 16 bit read

  // OR-plane, one group per target state
  assign toIdle  = terms[T_NEXT_ABORT] | terms[T_DONE_EXIT];
  assign toNext  = terms[T_IDLE_START] | terms[T_ACK32_MORE] | terms[T_ACK16_MORE];
  assign toReq   = terms[T_NEXT_WR] | terms[T_NEXT_RD] | terms[T_FLUSH_FREE] |
                   terms[T_HALF_REGRANT];
  assign toAddr  = terms[T_REQ_GRANT] | terms[T_HALF_GRANT];
  assign toWait  = terms[T_ADDR_WAIT];
  assign toAck16 = terms[T_ACK16_LO];
  assign toDone  = terms[T_NEXT_FLUSH] | terms[T_ACK32_LAST] | terms[T_ACK16_LAST];
  assign toFlush = terms[T_NEXT_FULL];

  always_comb begin
    nextState = state;  // no term, hold
    if (toIdle)
      nextState = S_IDLE;
    if (toNext)
      nextState = S_NEXT;
    if (toReq)
      nextState = S_REQ;
    if (toAddr)
      nextState = S_ADDR;
    if (toWait)
      nextState = S_WAITACK;
    if (toAck16)
      nextState = S_ACK16;
    if (toDone)
      nextState = S_DONE;
    if (toFlush)
      nextState = S_FLUSH;
  end

  assign wordDone = terms[T_BUS_POP] | terms[T_BUS_PUSH];

  // side strobes act on the ack edge itself
  assign fifoPopBus   = terms[T_BUS_POP];
  assign fifoPushBus  = terms[T_BUS_PUSH];
  assign addrAdvance  = wordDone | terms[T_HALF_DONE];
  assign halfStep     = terms[T_HALF_DONE];
  assign fifoPushData = flags.a1 ? {busDataIn[HALF_W-1:0], lowHalf} : busDataIn;

  always_ff @(posedge CLK) begin
    if (!rstN) begin
      state     <= S_IDLE;
      busOut    <= '0;
      cycleDone <= 1'b0;
      done      <= 1'b0;
    end else begin
      state             <= nextState;
      busOut.busReq     <= toReq | (terms[T_BUSREQ] & ~wordDone);  // held across halves
      busOut.addrStrobe <= toAddr | terms[T_STROBE];
      busOut.dataStrobe <= toAddr | terms[T_STROBE];
      busOut.addr       <= addr;
      if (toAddr) begin
        busOut.readWrite <= ~flags.toMemory;
        // upper half goes out on the low lanes too for a 16 bit slave
        busOut.dataOut   <= flags.a1 ? {2{fifoData[WORD_W-1:HALF_W]}} : fifoData;
      end
      cycleDone <= ~busOut.addrStrobe & (flags.dsackN == 2'b11);  // slave let go
      done      <= toDone;
    end
  end

  always_ff @(posedge CLK) begin
    if (terms[T_ACK16_LO])
      lowHalf <= busDataIn[HALF_W-1:0];
  end

  strobeNeedsGrant: assert property (@(posedge CLK) disable iff (!rstN)
    busOut.addrStrobe |-> !flags.grantN)
    else $error("cpuSmCore: address strobe high while bus not granted");

  stateIsNamed: assert property (@(posedge CLK) disable iff (!rstN)
    state inside {S_IDLE, S_NEXT, S_REQ, S_DONE, S_ADDR, S_FLUSH, S_ACK16, S_WAITACK})
    else $error("cpuSmCore: unknown state code %0d", state);

endmodule

`default_nettype wire

// File: src/sdmacCpuTop.sv
`timescale 1ns/100ps
`default_nettype none

module sdmacCpuTop #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                        CLK,
  input  logic                        rstN,
  input  sdmacPkg::dmaCtrl_t          ctrl,
  input  logic                        load,
  input  logic [sdmacPkg::ADDR_W-1:0] startAddr,
  input  logic [sdmacPkg::CNT_W-1:0]  wordCount,
  input  logic                        hostPush,
  input  logic [sdmacPkg::WORD_W-1:0] hostPushData,
  input  logic                        hostPop,
  output logic [sdmacPkg::WORD_W-1:0] hostPopData,
  input  logic                        busGrantN,
  input  logic [1:0]                  dsackN,
  input  logic [sdmacPkg::WORD_W-1:0] busDataIn,
  output sdmacPkg::cpuBusOut_t        busOut,
  output logic                        done
);

  import sdmacPkg::*;

  smFlags_t             flags;
  smState_t             state;
  logic [NUM_TERMS-1:0] terms;
  logic                 fifoEmpty;
  logic                 fifoFull;
  logic                 fifoPush;
  logic                 fifoPop;
  logic                 fifoClear;
  logic                 fifoPushBus;
  logic                 fifoPopBus;
  logic [WORD_W-1:0]    fifoPushData;
  logic [WORD_W-1:0]    fifoWrData;
  logic [WORD_W-1:0]    fifoRdData;
  logic [ADDR_W-1:0]    addr;
  logic                 a1;
  logic                 lastWord;
  logic                 addrAdvance;
  logic                 halfStep;
  logic                 cycleDone;

  assign flags = '{
    enable:    ctrl.enable,
    toMemory:  ctrl.toMemory,
    flush:     ctrl.flush,
    fifoEmpty: fifoEmpty,
    fifoFull:  fifoFull,
    lastWord:  lastWord,
    a1:        a1,
    grantN:    busGrantN,
    cycleDone: cycleDone,
    dsackN:    dsackN
  };

  // host fills on memory writes, drains on reads
  assign fifoPush    = ctrl.toMemory ? hostPush : fifoPushBus;
  assign fifoWrData  = ctrl.toMemory ? hostPushData : fifoPushData;
  assign fifoPop     = ctrl.toMemory ? fifoPopBus : hostPop;
  assign fifoClear   = ctrl.flush & (state == S_IDLE);
  assign hostPopData = fifoRdData;

  dmaFifo #(
    .DEPTH(FIFO_DEPTH)
  ) fifo (
    .CLK      (CLK),
    .rstN     (rstN),
    .clear    (fifoClear),
    .push     (fifoPush),
    .pushData (fifoWrData),
    .pop      (fifoPop),
    .popData  (fifoRdData),
    .empty    (fifoEmpty),
    .full     (fifoFull)
  );

  dmaAddrCounter addrCounter (
    .CLK       (CLK),
    .rstN      (rstN),
    .load      (load),
    .startAddr (startAddr),
    .wordCount (wordCount),
    .advance   (addrAdvance),
    .halfStep  (halfStep),
    .addr      (addr),
    .a1        (a1),
    .lastWord  (lastWord)
  );

  cpuSmInputs smInputs (
    .state (state),
    .flags (flags),
    .terms (terms)
  );

  cpuSmCore smCore (
    .CLK          (CLK),
    .rstN         (rstN),
    .terms        (terms),
    .flags        (flags),
    .fifoData     (fifoRdData),
    .busDataIn    (busDataIn),
    .addr         (addr),
    .state        (state),
    .busOut       (busOut),
    .fifoPushBus  (fifoPushBus),
    .fifoPushData (fifoPushData),
    .fifoPopBus   (fifoPopBus),
    .addrAdvance  (addrAdvance),
    .halfStep     (halfStep),
    .cycleDone    (cycleDone),
    .done         (done)
  );

endmodule

`default_nettype wire

// File: tests/tbSdmacCpu.sv
`timescale 1ns/100ps
`default_nettype none

module tbSdmacCpu;

  import sdmacPkg::*;

  localparam int FIFO_DEPTH  = 8;
  localparam int MAX_DELAY   = 3;    // slave grant and ack delay, cycles
  localparam int GOLD_LEN    = 128;
  localparam int MEM_HALVES  = 1024;
  localparam int SLV_IDLE    = 0;
  localparam int SLV_DELAY   = 1;
  localparam int SLV_ACKED   = 2;
  localparam int SLV_RELEASE = 3;

  logic              CLK;
  logic              rstN;
  dmaCtrl_t          ctrl;
  logic              load;
  logic [ADDR_W-1:0] startAddr;
  logic [CNT_W-1:0]  wordCount;
  logic              hostPush;
  logic [WORD_W-1:0] hostPushData;
  logic              hostPop;
  logic [WORD_W-1:0] hostPopData;
  logic              busGrantN = 1'b1;
  logic [1:0]        dsackN    = 2'b11;
  logic [WORD_W-1:0] busDataIn = '0;
  cpuBusOut_t        busOut;
  logic              done;

  logic [31:0]       golden [GOLD_LEN];
  logic [15:0]       slaveMem [MEM_HALVES];  // 16 bit lanes, low half at lower address
  logic [WORD_W-1:0] expData [16];
  logic              portIs16 = 1'b0;
  int                valueErrors = 0;
  int                protocolErrors = 0;
  int                cycleCount = 0;
  int                cycleLimit = 100000;
  int                ackCount = 0;         // bus cycles acked, halves included
  int                readAcks = 0;         // whole words pushed into the fifo
  int                doneCount = 0;
  int                gntCnt = 0;
  int                ackCnt = 0;
  int                slvState = SLV_IDLE;

  sdmacCpuTop #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) UUT (
    .CLK          (CLK),
    .rstN         (rstN),
    .ctrl         (ctrl),
    .load         (load),
    .startAddr    (startAddr),
    .wordCount    (wordCount),
    .hostPush     (hostPush),
    .hostPushData (hostPushData),
    .hostPop      (hostPop),
    .hostPopData  (hostPopData),
    .busGrantN    (busGrantN),
    .dsackN       (dsackN),
    .busDataIn    (busDataIn),
    .busOut       (busOut),
    .done         (done)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount > cycleLimit) begin
      $display("timeout: transfers still running after %0d cycles", cycleLimit);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  task automatic checkWord(input string name, input logic [WORD_W-1:0] expected,
                           input logic [WORD_W-1:0] actual);
    if (actual !== expected) begin
      $display("FAILED %0t %s expected %h got %h", $time, name, expected, actual);
      valueErrors++;
    end
  endtask

  task automatic checkAddr(input string name, input logic [ADDR_W-1:0] expected,
                           input logic [ADDR_W-1:0] actual);
    if (actual !== expected) begin
      $display("FAILED %0t %s expected %h got %h", $time, name, expected, actual);
      valueErrors++;
    end
  endtask

  task automatic checkBus(input string name, input cpuBusOut_t expected,
                          input cpuBusOut_t actual);
    if (actual !== expected) begin
      $display("FAILED %0t %s expected %h got %h", $time, name, expected, actual);
      valueErrors++;
    end
  endtask

  // slave answer for the cycle on the bus right now
  task automatic serveBusCycle();
    int h;
    h = int'(busOut.addr[10:1]);
    dsackN <= portIs16 ? 2'b01 : 2'b00;
    if (busOut.readWrite) begin
      if (portIs16)
        busDataIn <= {~slaveMem[h], slaveMem[h]};  // upper lanes carry junk
      else
        busDataIn <= {slaveMem[h+1], slaveMem[h]};
    end else begin
      slaveMem[h] = busOut.dataOut[15:0];
      if (!portIs16)
        slaveMem[h+1] = busOut.dataOut[31:16];
    end
  endtask

  // bus slave, grant and ack with random delays
  always @(posedge CLK) begin
    if (!rstN) begin
      slvState = SLV_IDLE;
      busGrantN <= 1'b1;
      dsackN    <= 2'b11;
    end else begin
      if (busOut.addrStrobe && busGrantN) begin
        $display("%0t: address strobe high while the bus is not granted", $time);
        protocolErrors <= protocolErrors + 1;
      end
      if (busOut.dataStrobe !== busOut.addrStrobe) begin
        $display("%0t: data strobe does not follow the address strobe", $time);
        protocolErrors <= protocolErrors + 1;
      end
      if (busGrantN) begin
        if (!busOut.busReq)
          gntCnt = $urandom_range(MAX_DELAY, 0);
        else if (gntCnt == 0)
          busGrantN <= 1'b0;
        else
          gntCnt = gntCnt - 1;
      end else if (!busOut.busReq && !busOut.addrStrobe) begin
        busGrantN <= 1'b1;  // master let go
      end
      case (slvState)
        SLV_IDLE: begin
          if (busOut.addrStrobe) begin
            ackCnt   = $urandom_range(MAX_DELAY, 0);
            slvState = SLV_DELAY;
          end
        end
        SLV_DELAY: begin
          if (!busOut.addrStrobe) begin
            $display("%0t: address strobe dropped before the slave acked", $time);
            protocolErrors <= protocolErrors + 1;
            slvState = SLV_IDLE;
          end else if (ackCnt == 0) begin
            serveBusCycle();
            slvState = SLV_ACKED;
          end else begin
            ackCnt = ackCnt - 1;
          end
        end
        SLV_ACKED: begin
          if (!busOut.addrStrobe) begin
            $display("%0t: address strobe dropped in the ack cycle", $time);
            protocolErrors <= protocolErrors + 1;
          end
          dsackN   <= 2'b11;
          ackCount <= ackCount + 1;
          if (busOut.readWrite && (!portIs16 || busOut.addr[1]))
            readAcks <= readAcks + 1;  // word now in fifo
          slvState = SLV_RELEASE;
        end
        default: begin
          if (!busOut.addrStrobe)
            slvState = SLV_IDLE;
        end
      endcase
      doneCount <= doneCount + int'(done);
    end
  end

  task automatic runTransfer(input int base);
    logic              toMem;
    logic              flushReq;
    logic [ADDR_W-1:0] start;
    logic [ADDR_W-1:0] finalAddr;
    int                count;
    int                numData;
    int                popAfter;
    int                popped;
    int                ackBase;
    int                readBase;
    int                doneBase;
    int                halves;
    int                h;
    int                i;
    bit                doneSeen;
    bit                popStarted;
    bit                popNow;
    toMem     = golden[base][0];
    portIs16  = (golden[base+1] == 32'h10);
    flushReq  = golden[base+2][0];
    popAfter  = golden[base+3];
    start     = golden[base+4][ADDR_W-1:0];
    count     = golden[base+5];
    numData   = golden[base+6];
    for (i = 0; i < numData; i++)
      expData[i] = golden[base+7+i];
    finalAddr = golden[base+7+numData][ADDR_W-1:0];
    if (!toMem) begin
      for (i = 0; i < numData; i++) begin
        h = int'(start[10:1]) + 2 * i;
        slaveMem[h]   = expData[i][15:0];
        slaveMem[h+1] = expData[i][31:16];
      end
    end
    ackBase  = ackCount;
    readBase = readAcks;
    doneBase = doneCount;
    @(posedge CLK);
    ctrl      <= '{enable: 1'b0, toMemory: toMem, flush: 1'b0};
    load      <= 1'b1;
    startAddr <= start;
    wordCount <= CNT_W'(count);
    @(posedge CLK);
    load <= 1'b0;
    if (toMem) begin
      for (i = 0; i < numData; i++) begin
        hostPush     <= 1'b1;
        hostPushData <= expData[i];
        @(posedge CLK);
      end
    end
    hostPush    <= 1'b0;
    ctrl.enable <= 1'b1;
    @(posedge CLK);
    ctrl.flush <= flushReq;  // only once out of idle, idle plus flush clears the fifo
    popped     = 0;
    doneSeen   = 1'b0;
    popStarted = 1'b0;
    popNow     = 1'b0;
    while (!doneSeen || (!toMem && popped < numData)) begin
      @(posedge CLK);
      if (done)
        doneSeen = 1'b1;
      if (popNow) begin
        checkWord($sformatf("hostPopData word %0d", popped), expData[popped], hostPopData);
        popped++;
      end
      if (readAcks - readBase >= popAfter)
        popStarted = 1'b1;
      popNow  = !toMem && popStarted && (readAcks - readBase > popped);
      hostPop <= popNow;
    end
    hostPop     <= 1'b0;
    ctrl.enable <= 1'b0;
    ctrl.flush  <= 1'b0;
    repeat (6) @(posedge CLK);
    checkAddr("busOut.addr", finalAddr, busOut.addr);
    halves = (toMem ? numData : count) * (portIs16 ? 2 : 1);
    checkWord("bus cycles", WORD_W'(halves), WORD_W'(ackCount - ackBase));
    checkWord("done pulses", WORD_W'(1), WORD_W'(doneCount - doneBase));
    if (toMem) begin
      for (i = 0; i < numData; i++) begin
        h = int'(start[10:1]) + 2 * i;
        checkWord($sformatf("slave memory word %0d", i), expData[i],
                  {slaveMem[h+1], slaveMem[h]});
      end
    end
  endtask

  initial begin
    int ptr;
    int nXfer;
    int totalWords;
    int x;
    int i;
    void'($urandom(32'h632fa78f));
    rstN         = 1'b0;
    ctrl         = '0;
    load         = 1'b0;
    startAddr    = '0;
    wordCount    = '0;
    hostPush     = 1'b0;
    hostPushData = '0;
    hostPop      = 1'b0;
    for (i = 0; i < MEM_HALVES; i++)
      slaveMem[i] = 16'((i * 40503) ^ 23130);  // spread over all index bits
    $readmemh("tests/cpuSmGolden.txt", golden);
    nXfer = 0;
    if ($isunknown(golden[0]) || golden[0] == 0)
      $display("golden file missing or holds no transfers");
    else
      nXfer = golden[0];
    // record is 7 header words, the data, then the final address
    ptr = 1;
    totalWords = 0;
    for (x = 0; x < nXfer; x++) begin
      totalWords += golden[ptr+5];
      ptr += 8 + golden[ptr+6];
    end
    cycleLimit = totalWords * 2 * 2 * (MAX_DELAY + 4) + 100 * nXfer + 100;
    repeat (2) @(posedge CLK);
    rstN <= 1'b1;
    @(posedge CLK);
    checkBus("busOut after reset", '0, busOut);
    checkWord("done after reset", '0, WORD_W'(done));
    ptr = 1;
    for (x = 0; x < nXfer; x++) begin
      runTransfer(ptr);
      ptr += 8 + golden[ptr+6];
    end
    repeat (4) @(posedge CLK);
    $display("errors: %0d value, %0d protocol", valueErrors, protocolErrors);
    if (nXfer > 0 && valueErrors == 0 && protocolErrors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/cpuSmGolden.txt
// hex: number of transfers, then per transfer
// toMemory width(20 or 10) flush popAfter startAddr wordCount numData, data words, final addr
6
1 20 0 0 000100 4 4 1234ABCD 0BADF00D 80000001 7FFE0002 000110
0 20 0 0 000200 4 4 CAFEBABE 00C0FFEE 5A5AA5A5 FFFF0000 000210
1 10 0 0 000300 3 3 11112222 33334444 DEADBEEF 00030C
0 10 0 0 000400 3 3 0F0F1E1E 89ABCDEF 76543210 00040C
// write of 6 words with only 3 pushed, ended by flush
1 20 1 0 000500 6 3 A0A0B1B1 C2C2D3D3 E4E4F5F5 00050C
// read of 10 words, host starts popping once the fifo holds 8
0 20 0 8 000600 A A 00000001 00000002 00000004 00000008 00000010
  00000020 00000040 00000080 00000100 80000200
  000628

// File: project.f
src/sdmacPkg.sv
src/dmaFifo.sv
src/dmaAddrCounter.sv
src/cpuSmInputs.sv
src/cpuSmCore.sv
src/sdmacCpuTop.sv
tests/tbSdmacCpu.sv

// File: runSim.sh
#!/bin/sh
# build and run the testbench with Verilator, pass only on the pass line in the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f project.f \
  --top-module tbSdmacCpu -o simTb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/simTb > "$LOG" 2>&1
SIMSTATUS=$?
cat "$LOG"
if [ $SIMSTATUS -ne 0 ]; then
  echo "simulation exited with status $SIMSTATUS"
  exit 1
fi

if grep -qx "STATUS: PASS" "$LOG"; then
  exit 0
fi
echo "pass line not found in $LOG"
exit 1
